// ==== verilog/spi_reg_pkg.sv ====
`default_nettype none

package spi_reg_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // command byte, bit 7 selects a write
  typedef enum logic [7:0] {
    CMD_READ  = 8'h00,
    CMD_WRITE = 8'h80
  } spi_cmd_e;

  // system block window
  localparam logic [ADDR_W-1:0] SYS_BASE = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] SYS_HIGH = 32'h0000_00FF;

  // general control register window
  localparam logic [ADDR_W-1:0] CTRL_BASE = 32'h0000_0100;
  localparam logic [ADDR_W-1:0] CTRL_HIGH = 32'h0000_01FF;

  // read data seen by the host when a cycle ends in err
  localparam logic [DATA_W-1:0] ERR_DATA = 32'hDEAD_BEEF;

endpackage

`default_nettype wire

// ==== verilog/wb_bus_if.sv ====
`default_nettype none

interface wb_bus_if;

  logic                            cyc;
  logic                            stb;
  logic                            we;
  logic [spi_reg_pkg::ADDR_W-1:0]  adr;
  logic [spi_reg_pkg::DATA_W-1:0]  dat_w;
  logic [spi_reg_pkg::DATA_W-1:0]  dat_r;
  logic                            ack;
  logic                            err;

  modport master (
    output cyc,
    output stb,
    output we,
    output adr,
    output dat_w,
    input  dat_r,
    input  ack,
    input  err
  );

  modport slave (
    input  cyc,
    input  stb,
    input  we,
    input  adr,
    input  dat_w,
    output dat_r,
    output ack,
    output err
  );

endinterface

`default_nettype wire

// ==== verilog/spi_wb_bridge.sv ====
`default_nettype none

module spi_wb_bridge (
  input  wire       sys_clk,
  input  wire       rst_i,
  input  wire       cs_n_i,
  input  wire       sclk_i,
  input  wire       mosi_i,
  output logic      miso_o,
  output logic      new_cmd_o,
  wb_bus_if.master  wb
);

  localparam int DATA_W = spi_reg_pkg::DATA_W;
  localparam int ADDR_W = spi_reg_pkg::ADDR_W;

  // 1 cmd byte, 4 address bytes, 4 data bytes
  localparam logic [6:0] FRAME_BITS = 7'd72;
  localparam logic [6:0] RESP_START = 7'd40;

  typedef enum logic [1:0] {
    IDLE,
    SHIFT,
    BUS,
    DONE
  } state_e;

  state_e                state_q;
  logic [1:0]            cs_q;
  logic [1:0]            sclk_q;
  logic                  mosi_q;
  logic [6:0]            bit_cnt_q;
  logic [71:0]           frame_q;
  logic [DATA_W-1:0]     resp_q;
  logic [DATA_W-1:0]     resp_sh_q;
  logic                  miso_q;
  logic                  cyc_q;
  logic                  stb_q;
  logic                  we_q;
  logic [ADDR_W-1:0]     adr_q;
  logic [DATA_W-1:0]     dat_w_q;
  logic                  rd_pend_q;
  spi_reg_pkg::spi_cmd_e cmd;
  logic                  cs_fall;
  logic                  cs_rise;
  logic                  sclk_rise;
  logic                  sclk_fall;
  logic                  shift_in;
  logic                  shift_out;

  assign cs_fall   = cs_q[1] & ~cs_q[0];
  assign cs_rise   = ~cs_q[1] & cs_q[0];
  assign sclk_rise = ~sclk_q[1] & sclk_q[0];
  assign sclk_fall = sclk_q[1] & ~sclk_q[0];

  assign shift_in  = (state_q == SHIFT) && !cs_rise && sclk_rise && (bit_cnt_q != FRAME_BITS);
  // response occupies the four data bytes
  assign shift_out = (state_q == SHIFT) && !cs_rise && sclk_fall &&
                     (bit_cnt_q >= RESP_START) && (bit_cnt_q < FRAME_BITS);

  // only bit 7 of the command byte matters
  assign cmd = frame_q[71] ? spi_reg_pkg::CMD_WRITE : spi_reg_pkg::CMD_READ;

  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      cs_q   <= 2'b11;
      sclk_q <= 2'b00;
    end else begin
      cs_q   <= {cs_q[0], cs_n_i};
      sclk_q <= {sclk_q[0], sclk_i};
    end
  end

  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      state_q   <= IDLE;
      bit_cnt_q <= '0;
      miso_q    <= 1'b0;
      cyc_q     <= 1'b0;
      stb_q     <= 1'b0;
      resp_q    <= '0;
      rd_pend_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (cs_fall) begin
            state_q   <= SHIFT;
            bit_cnt_q <= '0;
            miso_q    <= 1'b0;
          end
        end
        SHIFT: begin
          if (cs_rise) begin
            miso_q <= 1'b0;
            // short frames are dropped
            if (bit_cnt_q == FRAME_BITS) begin
              rd_pend_q <= 1'b0;
              // read-back slot only carries the response out
              if (rd_pend_q && cmd == spi_reg_pkg::CMD_READ) begin
                state_q <= IDLE;
              end else begin
                cyc_q   <= 1'b1;
                stb_q   <= 1'b1;
                state_q <= BUS;
              end
            end else begin
              state_q <= IDLE;
            end
          end else begin
            if (shift_in) begin
              bit_cnt_q <= bit_cnt_q + 7'd1;
            end
            if (shift_out) begin
              miso_q <= resp_sh_q[DATA_W-1];
            end
          end
        end
        BUS: begin
          if (wb.ack || wb.err) begin
            cyc_q     <= 1'b0;
            stb_q     <= 1'b0;
            state_q   <= DONE;
            rd_pend_q <= !we_q;
            if (wb.err) begin
              resp_q <= spi_reg_pkg::ERR_DATA;
            end else if (!we_q) begin
              resp_q <= wb.dat_r;
            end
          end
        end
        DONE: state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    mosi_q <= mosi_i;
    if (shift_in) begin
      frame_q <= {frame_q[70:0], mosi_q};
    end
    if (state_q == IDLE && cs_fall) begin
      resp_sh_q <= resp_q;
    end else if (shift_out) begin
      resp_sh_q <= {resp_sh_q[DATA_W-2:0], 1'b0};
    end
    if (state_q == SHIFT && cs_rise) begin
      we_q    <= (cmd == spi_reg_pkg::CMD_WRITE);
      adr_q   <= frame_q[63:32];
      dat_w_q <= frame_q[31:0];
    end
  end

  assign wb.cyc   = cyc_q;
  assign wb.stb   = stb_q;
  assign wb.we    = we_q;
  assign wb.adr   = adr_q;
  assign wb.dat_w = dat_w_q;

  assign miso_o    = miso_q;
  assign new_cmd_o = (state_q == DONE);

endmodule

`default_nettype wire

// ==== verilog/wb_addr_decoder.sv ====
`default_nettype none

module wb_addr_decoder #(
  parameter int TIMEOUT = 64
) (
  input  wire       sys_clk,
  input  wire       rst_i,
  wb_bus_if.slave   m,
  wb_bus_if.master  sys_s,
  wb_bus_if.master  ctrl_s
);

  localparam int CNT_W = $clog2(TIMEOUT + 1);

  logic             sys_hit;
  logic             ctrl_hit;
  logic             any_hit;
  logic             slv_ack;
  logic             slv_err;
  logic             err_q;
  logic [CNT_W-1:0] to_cnt_q;

  assign sys_hit  = (m.adr >= spi_reg_pkg::SYS_BASE) && (m.adr <= spi_reg_pkg::SYS_HIGH);
  assign ctrl_hit = (m.adr >= spi_reg_pkg::CTRL_BASE) && (m.adr <= spi_reg_pkg::CTRL_HIGH);
  assign any_hit  = sys_hit | ctrl_hit;

  // the timeout err drops the cycle at the slave
  assign sys_s.cyc    = m.cyc & sys_hit & ~err_q;
  assign sys_s.stb    = m.stb & sys_hit & ~err_q;
  assign sys_s.we     = m.we;
  assign sys_s.adr    = m.adr;
  assign sys_s.dat_w  = m.dat_w;

  assign ctrl_s.cyc   = m.cyc & ctrl_hit & ~err_q;
  assign ctrl_s.stb   = m.stb & ctrl_hit & ~err_q;
  assign ctrl_s.we    = m.we;
  assign ctrl_s.adr   = m.adr;
  assign ctrl_s.dat_w = m.dat_w;

  assign slv_ack = (sys_hit & sys_s.ack) | (ctrl_hit & ctrl_s.ack);
  assign slv_err = (sys_hit & sys_s.err) | (ctrl_hit & ctrl_s.err);

  always_comb begin
    if (sys_hit) begin
      m.dat_r = sys_s.dat_r;
    end else if (ctrl_hit) begin
      m.dat_r = ctrl_s.dat_r;
    end else begin
      m.dat_r = '0;
    end
  end

  assign m.ack = slv_ack & ~err_q;
  assign m.err = err_q | slv_err;

  // unmapped address or no ack in time
  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      err_q    <= 1'b0;
      to_cnt_q <= '0;
    end else begin
      err_q <= 1'b0;
      if (m.cyc && m.stb && !err_q && !slv_ack) begin
        if (!any_hit) begin
          err_q <= 1'b1;
        end else if (to_cnt_q == CNT_W'(TIMEOUT - 1)) begin
          err_q    <= 1'b1;
          to_cnt_q <= '0;
        end else begin
          to_cnt_q <= to_cnt_q + 1'b1;
        end
      end else begin
        to_cnt_q <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/sys_block.sv ====
`default_nettype none

module sys_block #(
  parameter logic [7:0] BOARD_ID = 8'd12,
  parameter logic [7:0] REV_MAJ  = 8'd1,
  parameter logic [7:0] REV_MIN  = 8'd0
) (
  input  wire      sys_clk,
  input  wire      rst_i,
  wb_bus_if.slave  wb
);

  localparam int DATA_W = spi_reg_pkg::DATA_W;

  logic              req;
  logic              ack_q;
  logic [DATA_W-1:0] dat_r_q;
  logic [DATA_W-1:0] scratch_q;
  logic [DATA_W-1:0] uptime_q;

  assign req = wb.cyc & wb.stb & ~ack_q;

  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      ack_q     <= 1'b0;
      scratch_q <= '0;
      uptime_q  <= '0;
    end else begin
      ack_q    <= req;
      uptime_q <= uptime_q + 1'b1;
      // only the scratch word takes writes
      if (req && wb.we && wb.adr[7:2] == 6'd1) begin
        scratch_q <= wb.dat_w;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (req) begin
      case (wb.adr[7:2])
        6'd0:    dat_r_q <= {BOARD_ID, REV_MAJ, REV_MIN, 8'h00};
        6'd1:    dat_r_q <= scratch_q;
        6'd2:    dat_r_q <= uptime_q;
        default: dat_r_q <= '0;
      endcase
    end
  end

  assign wb.ack   = ack_q;
  assign wb.dat_r = dat_r_q;
  assign wb.err   = 1'b0;

endmodule

`default_nettype wire

// ==== verilog/ctrl_regs.sv ====
`default_nettype none

module ctrl_regs (
  input  wire      sys_clk,
  input  wire      rst_i,
  wb_bus_if.slave  wb
);

  localparam int DATA_W = spi_reg_pkg::DATA_W;

  logic              req;
  logic              ack_q;
  logic [1:0]        idx;
  logic [DATA_W-1:0] regs_q [4];
  logic [DATA_W-1:0] dat_r_q;

  assign req = wb.cyc & wb.stb & ~ack_q;
  // word index, aliases every 16 bytes
  assign idx = wb.adr[3:2];

  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      ack_q <= 1'b0;
      for (int i = 0; i < 4; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      ack_q <= req;
      if (req && wb.we) begin
        regs_q[idx] <= wb.dat_w;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (req) begin
      dat_r_q <= regs_q[idx];
    end
  end

  assign wb.ack   = ack_q;
  assign wb.dat_r = dat_r_q;
  assign wb.err   = 1'b0;

endmodule

`default_nettype wire

// ==== verilog/spi_reg_top.sv ====
`default_nettype none

module spi_reg_top #(
  parameter logic [7:0] BOARD_ID = 8'd12,
  parameter logic [7:0] REV_MAJ  = 8'd1,
  parameter logic [7:0] REV_MIN  = 8'd0,
  parameter int         TIMEOUT  = 64
) (
  input  wire  sys_clk,
  input  wire  reset_i,
  input  wire  cs_n_i,
  input  wire  sclk_i,
  input  wire  mosi_i,
  output logic miso_o,
  output logic new_cmd_o
);

  logic [1:0] rst_q;
  logic       rst;

  // two flops on the external reset
  always_ff @(posedge sys_clk) begin
    rst_q <= {rst_q[0], reset_i};
  end

  assign rst = rst_q[1];

  wb_bus_if m_bus ();
  wb_bus_if s_sys ();
  wb_bus_if s_ctrl ();

  spi_wb_bridge u_bridge (
    .sys_clk   (sys_clk),
    .rst_i     (rst),
    .cs_n_i    (cs_n_i),
    .sclk_i    (sclk_i),
    .mosi_i    (mosi_i),
    .miso_o    (miso_o),
    .new_cmd_o (new_cmd_o),
    .wb        (m_bus.master)
  );

  wb_addr_decoder #(
    .TIMEOUT (TIMEOUT)
  ) u_decoder (
    .sys_clk (sys_clk),
    .rst_i   (rst),
    .m       (m_bus.slave),
    .sys_s   (s_sys.master),
    .ctrl_s  (s_ctrl.master)
  );

  sys_block #(
    .BOARD_ID (BOARD_ID),
    .REV_MAJ  (REV_MAJ),
    .REV_MIN  (REV_MIN)
  ) u_sys (
    .sys_clk (sys_clk),
    .rst_i   (rst),
    .wb      (s_sys.slave)
  );

  ctrl_regs u_ctrl (
    .sys_clk (sys_clk),
    .rst_i   (rst),
    .wb      (s_ctrl.slave)
  );

endmodule

`default_nettype wire

// ==== tb/spi_reg_tb.sv ====
`default_nettype none

module spi_reg_tb;

  localparam int DW = spi_reg_pkg::DATA_W;
  localparam int AW = spi_reg_pkg::ADDR_W;

  localparam logic [7:0] BOARD_ID = 8'hA5;
  localparam logic [7:0] REV_MAJ  = 8'h02;
  localparam logic [7:0] REV_MIN  = 8'h13;

  // sclk period of 10 sys_clk cycles
  localparam int SCLK_HALF    = 5;
  localparam int FRAME_CYCLES = 4 + 72 * 2 * SCLK_HALF + SCLK_HALF + 1;
  localparam int CMD_WAIT     = 200;
  // a bus cycle would finish well inside this window
  localparam int QUIET_WAIT   = 16;
  // frames over all six tests, the ctrl bank test alone needs 14
  localparam int NUM_FRAMES   = 28;
  localparam int MAX_CYCLES   = 20 + NUM_FRAMES * (FRAME_CYCLES + CMD_WAIT);

  logic sys_clk;
  logic reset_i;
  logic cs_n;
  logic sclk;
  logic mosi;
  logic miso;
  logic new_cmd;

  int err_cnt      = 0;
  int tests_run    = 0;
  int tests_failed = 0;
  int cycle_cnt    = 0;

  spi_reg_top #(
    .BOARD_ID (BOARD_ID),
    .REV_MAJ  (REV_MAJ),
    .REV_MIN  (REV_MIN),
    .TIMEOUT  (64)
  ) dut (
    .sys_clk   (sys_clk),
    .reset_i   (reset_i),
    .cs_n_i    (cs_n),
    .sclk_i    (sclk),
    .mosi_i    (mosi),
    .miso_o    (miso),
    .new_cmd_o (new_cmd)
  );

  initial begin
    sys_clk = 1'b0;
    forever #5 sys_clk = ~sys_clk;
  end

  always @(posedge sys_clk) begin
    cycle_cnt++;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // inputs change 1 time unit after the rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge sys_clk);
    #1;
  endtask

  task automatic check_data(input string name, input logic [DW-1:0] got,
                            input logic [DW-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_increase(input string name, input logic [DW-1:0] first,
                                input logic [DW-1:0] second);
    if (!(second > first)) begin
      $display("[FAIL] %s: 0x%08h is not above 0x%08h", name, second, first);
      err_cnt++;
    end
  endtask

  task automatic check_cmd_done(input string what, input bit seen);
    if (!seen) begin
      $display("error: new_cmd_o never pulsed after the %s frame", what);
      err_cnt++;
    end
  endtask

  task automatic check_no_cmd(input string what, input bit seen);
    if (seen) begin
      $display("error: new_cmd_o pulsed after the %s frame", what);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    tests_run++;
    if (err_cnt == errs_at_start) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, err_cnt - errs_at_start);
    end
  endtask

  // one 72-bit frame, MSB first; miso is sampled before each rising sclk
  task automatic spi_frame(input spi_reg_pkg::spi_cmd_e cmd, input logic [AW-1:0] addr,
                           input logic [DW-1:0] data, output logic [DW-1:0] rdata);
    logic [71:0] bits;
    bits  = {cmd, addr, data};
    rdata = '0;
    cs_n  = 1'b0;
    wait_cycles(4);
    for (int i = 71; i >= 0; i--) begin
      mosi = bits[i];
      wait_cycles(SCLK_HALF);
      if (i < DW) begin
        rdata = {rdata[DW-2:0], miso};
      end
      sclk = 1'b1;
      wait_cycles(SCLK_HALF);
      sclk = 1'b0;
    end
    wait_cycles(SCLK_HALF);
    cs_n = 1'b1;
    mosi = 1'b0;
  endtask

  task automatic await_cmd_done(input string what);
    bit seen;
    int n;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < CMD_WAIT) begin
      @(negedge sys_clk);
      seen = new_cmd;
      n++;
    end
    check_cmd_done(what, seen);
    wait_cycles(1);
  endtask

  // a frame without a bus cycle leaves new_cmd_o low
  task automatic await_quiet(input string what);
    bit seen;
    seen = 1'b0;
    repeat (QUIET_WAIT) begin
      @(negedge sys_clk);
      seen = seen | new_cmd;
    end
    check_no_cmd(what, seen);
    wait_cycles(1);
  endtask

  task automatic do_write(input logic [AW-1:0] addr, input logic [DW-1:0] data);
    logic [DW-1:0] unused;
    spi_frame(spi_reg_pkg::CMD_WRITE, addr, data, unused);
    await_cmd_done("write");
  endtask

  task automatic do_read(input logic [AW-1:0] addr, output logic [DW-1:0] rdata);
    logic [DW-1:0] unused;
    spi_frame(spi_reg_pkg::CMD_READ, addr, '0, unused);
    await_cmd_done("read");
    // the latched word comes out on miso in the read-back slot
    spi_frame(spi_reg_pkg::CMD_READ, '0, '0, rdata);
    await_quiet("read-back");
  endtask

  task automatic test_ctrl_reset();
    logic [DW-1:0] rd;
    int errs;
    errs = err_cnt;
    do_read(spi_reg_pkg::CTRL_BASE + 32'h04, rd);
    check_data("ctrl[1]", rd, '0);
    report_test("ctrl reset value", errs);
  endtask

  task automatic test_board_id();
    logic [DW-1:0] rd;
    int errs;
    errs = err_cnt;
    do_read(spi_reg_pkg::SYS_BASE, rd);
    check_data("board id", rd, {BOARD_ID, REV_MAJ, REV_MIN, 8'h00});
    report_test("board id", errs);
  endtask

  task automatic test_scratch();
    logic [DW-1:0] wr;
    logic [DW-1:0] rd;
    int errs;
    errs = err_cnt;
    wr   = $urandom;
    do_write(spi_reg_pkg::SYS_BASE + 32'h04, wr);
    do_read(spi_reg_pkg::SYS_BASE + 32'h04, rd);
    check_data("scratch", rd, wr);
    report_test("scratch", errs);
  endtask

  task automatic test_ctrl_bank();
    logic [DW-1:0] vals [4];
    logic [DW-1:0] rd;
    int errs;
    errs = err_cnt;
    for (int i = 0; i < 4; i++) begin
      vals[i] = $urandom;
      do_write(spi_reg_pkg::CTRL_BASE + AW'(4 * i), vals[i]);
    end
    for (int i = 0; i < 4; i++) begin
      do_read(spi_reg_pkg::CTRL_BASE + AW'(4 * i), rd);
      check_data($sformatf("ctrl[%0d]", i), rd, vals[i]);
    end
    // offset 0x10 wraps onto offset 0x00
    do_read(spi_reg_pkg::CTRL_BASE + 32'h10, rd);
    check_data("ctrl alias 0x10", rd, vals[0]);
    report_test("ctrl bank", errs);
  endtask

  task automatic test_uptime();
    logic [DW-1:0] first;
    logic [DW-1:0] second;
    int errs;
    errs = err_cnt;
    do_read(spi_reg_pkg::SYS_BASE + 32'h08, first);
    do_write(spi_reg_pkg::SYS_BASE + 32'h04, $urandom);
    do_read(spi_reg_pkg::SYS_BASE + 32'h08, second);
    check_increase("uptime", first, second);
    report_test("uptime", errs);
  endtask

  task automatic test_unmapped();
    logic [DW-1:0] rd;
    int errs;
    errs = err_cnt;
    do_read(32'h0000_1000, rd);
    check_data("unmapped read", rd, spi_reg_pkg::ERR_DATA);
    report_test("unmapped address", errs);
  endtask

  initial begin
    void'($urandom(32'h96e3));
    reset_i = 1'b1;
    cs_n    = 1'b1;
    sclk    = 1'b0;
    mosi    = 1'b0;
    wait_cycles(10);
    reset_i = 1'b0;
    // let the reset synchronizer clear
    wait_cycles(4);

    test_ctrl_reset();
    test_board_id();
    test_scratch();
    test_ctrl_bank();
    test_uptime();
    test_unmapped();

    $display("summary: %0d tests, %0d failed, %0d check errors",
             tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== spi_reg.f ====
verilog/spi_reg_pkg.sv
verilog/wb_bus_if.sv
verilog/spi_wb_bridge.sv
verilog/wb_addr_decoder.sv
verilog/sys_block.sv
verilog/ctrl_regs.sv
verilog/spi_reg_top.sv
tb/spi_reg_tb.sv

// ==== Bender.yml ====
package:
  name: spi_reg

sources:
  - verilog/spi_reg_pkg.sv
  - verilog/wb_bus_if.sv
  - verilog/spi_wb_bridge.sv
  - verilog/wb_addr_decoder.sv
  - verilog/sys_block.sv
  - verilog/ctrl_regs.sv
  - verilog/spi_reg_top.sv
  - target: test
    files:
      - tb/spi_reg_tb.sv
